/* list.f */
verilog/llc_pmu_pkg.sv
verilog/pmu_cfg_if.sv
verilog/edge_propagator_rx.sv
verilog/pmu_lite_slave.sv
verilog/pmu_counter_bank.sv
verilog/llc_event_monitor.sv
verification/llc_event_monitor_props.sv
verification/llc_event_monitor_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := llc_event_monitor_tb
FILELIST   := list.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/llc_event_monitor_tb.sv */
// Testbench for the LLC event monitor, compiled through list.f with this module as the top
`timescale 1ns/100ps

module llc_event_monitor_tb;

  localparam int unsigned NUM_EVENTS = 4;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned COUNT_CYCLES = 500;
  localparam int unsigned DMA_EDGES = 6;
  // Per test budget, one bus access needs at most about 8 cycles
  localparam int unsigned TEST_CYCLES = 80 + 280 + (COUNT_CYCLES + 120) + 40 + 100 + 80;
  localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES + 1000;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    dma_pe_evt_valid_i;
  logic                    dma_pe_evt_ack_o;
  logic                    dma_pe_evt_o;
  logic [NUM_EVENTS-1:0]   llc_events_i;
  logic                    cfg_aw_valid_i;
  llc_pmu_pkg::lite_addr_t cfg_aw_addr_i;
  logic                    cfg_aw_ready_o;
  logic                    cfg_w_valid_i;
  llc_pmu_pkg::lite_data_t cfg_w_data_i;
  logic                    cfg_w_ready_o;
  logic                    cfg_b_valid_o;
  logic                    cfg_b_ready_i;
  logic                    cfg_ar_valid_i;
  llc_pmu_pkg::lite_addr_t cfg_ar_addr_i;
  logic                    cfg_ar_ready_o;
  logic                    cfg_r_valid_o;
  llc_pmu_pkg::lite_data_t cfg_r_data_o;
  logic                    cfg_r_ready_i;
  logic [NUM_EVENTS-1:0]   pmu_intr_o;

  // Reference model of the register file
  llc_pmu_pkg::counter_t model_cnt [NUM_EVENTS];
  llc_pmu_pkg::counter_t model_thr [NUM_EVENTS];
  logic [NUM_EVENTS-1:0] model_en;
  logic [NUM_EVENTS-1:0] model_status;

  logic [31:0] rng_state = 32'h2e18_5af3;
  int unsigned cycle_cnt = 0;
  int unsigned pulse_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned fail_cnt = 0;

  llc_event_monitor #(.NUM_EVENTS (NUM_EVENTS)) DUT (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (!rst_i && dma_pe_evt_o) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic llc_pmu_pkg::lite_addr_t reg_addr(llc_pmu_pkg::lite_addr_t base, int idx);
    return base + llc_pmu_pkg::lite_addr_t'(4 * idx);
  endfunction

  function automatic void model_write(llc_pmu_pkg::lite_addr_t addr, llc_pmu_pkg::lite_data_t data);
    for (int i = 0; i < NUM_EVENTS; i++) begin
      if (addr == reg_addr(llc_pmu_pkg::CntBase, i))
        model_cnt[i] = data;
      if (addr == reg_addr(llc_pmu_pkg::ThrBase, i))
        model_thr[i] = data;
    end
    if (addr == llc_pmu_pkg::CtrlAddr)
      model_en = data[NUM_EVENTS-1:0];
    if (addr == llc_pmu_pkg::StatusAddr)
      model_status = model_status & ~data[NUM_EVENTS-1:0];
  endfunction

  // One clock edge of event strobes, saturating and raising status on a threshold hit
  function automatic void model_step(logic [NUM_EVENTS-1:0] ev);
    for (int i = 0; i < NUM_EVENTS; i++) begin
      if (ev[i] && model_en[i] && model_cnt[i] != 32'hffff_ffff) begin
        if (model_thr[i] != 32'd0 && model_cnt[i] + 32'd1 == model_thr[i])
          model_status[i] = 1'b1;
        model_cnt[i] = model_cnt[i] + 32'd1;
      end
    end
  endfunction

  function automatic llc_pmu_pkg::lite_data_t expected_read(llc_pmu_pkg::lite_addr_t addr);
    llc_pmu_pkg::lite_data_t val;
    val = llc_pmu_pkg::UnmappedData;
    for (int i = 0; i < NUM_EVENTS; i++) begin
      if (addr == reg_addr(llc_pmu_pkg::CntBase, i))
        val = model_cnt[i];
      if (addr == reg_addr(llc_pmu_pkg::ThrBase, i))
        val = model_thr[i];
    end
    if (addr == llc_pmu_pkg::CtrlAddr)
      val = llc_pmu_pkg::lite_data_t'(model_en);
    if (addr == llc_pmu_pkg::StatusAddr)
      val = llc_pmu_pkg::lite_data_t'(model_status);
    return val;
  endfunction

  function automatic void check_intr();
    assert (pmu_intr_o === model_status) else begin
      $display("ERR pmu_intr_o: expected %h, actual %h", model_status, pmu_intr_o);
      err_cnt++;
    end
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Master side back-pressure of 0 to 3 cycles
  task automatic stall();
    repeat (xorshift_next() & 32'd3) next_cycle();
  endtask

  task automatic bus_write(llc_pmu_pkg::lite_addr_t addr, llc_pmu_pkg::lite_data_t data);
    cfg_aw_valid_i = 1'b1;
    cfg_aw_addr_i  = addr;
    cfg_w_valid_i  = 1'b1;
    cfg_w_data_i   = data;
    while (!cfg_aw_ready_o) next_cycle();
    next_cycle();
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    model_write(addr, data);
    stall();
    cfg_b_ready_i = 1'b1;
    while (!cfg_b_valid_o) next_cycle();
    next_cycle();
    cfg_b_ready_i = 1'b0;
  endtask

  task automatic check_read(llc_pmu_pkg::lite_addr_t addr);
    llc_pmu_pkg::lite_data_t exp;
    llc_pmu_pkg::lite_data_t got;
    exp = expected_read(addr);
    cfg_ar_valid_i = 1'b1;
    cfg_ar_addr_i  = addr;
    while (!cfg_ar_ready_o) next_cycle();
    next_cycle();
    cfg_ar_valid_i = 1'b0;
    stall();
    cfg_r_ready_i = 1'b1;
    while (!cfg_r_valid_o) next_cycle();
    got = cfg_r_data_o;
    next_cycle();
    cfg_r_ready_i = 1'b0;
    assert (got === exp) else begin
      $display("ERR cfg_r_data_o at %h: expected %h, actual %h", addr, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_regs();
    for (int i = 0; i < NUM_EVENTS; i++) begin
      check_read(reg_addr(llc_pmu_pkg::CntBase, i));
      check_read(reg_addr(llc_pmu_pkg::ThrBase, i));
    end
    check_read(llc_pmu_pkg::CtrlAddr);
    check_read(llc_pmu_pkg::StatusAddr);
  endtask

  initial begin
    logic [31:0] rnd;
    int unsigned hold;
    int unsigned pulse_base;
    rst_i = 1'b1;
    dma_pe_evt_valid_i = 1'b0;
    llc_events_i = '0;
    cfg_aw_valid_i = 1'b0;
    cfg_aw_addr_i = '0;
    cfg_w_valid_i = 1'b0;
    cfg_w_data_i = '0;
    cfg_b_ready_i = 1'b0;
    cfg_ar_valid_i = 1'b0;
    cfg_ar_addr_i = '0;
    cfg_r_ready_i = 1'b0;
    for (int i = 0; i < NUM_EVENTS; i++) begin
      model_cnt[i] = '0;
      model_thr[i] = '0;
    end
    model_en = '0;
    model_status = '0;
    repeat (RESET_CYCLES) next_cycle();
    rst_i = 1'b0;
    next_cycle();
    check_regs();
    check_intr();

    // Random values, then unmapped reads and writes
    for (int i = 0; i < NUM_EVENTS; i++) begin
      bus_write(reg_addr(llc_pmu_pkg::ThrBase, i), xorshift_next());
      bus_write(reg_addr(llc_pmu_pkg::CntBase, i), xorshift_next());
    end
    check_regs();
    check_read(8'h30);
    check_read(8'h3c);
    check_read(8'h11);
    bus_write(8'h30, 32'hffff_ffff);
    bus_write(8'h28, xorshift_next());
    bus_write(8'h11, xorshift_next());
    check_regs();

    // Random strobes with counters 0 and 2 enabled
    for (int i = 0; i < NUM_EVENTS; i++)
      bus_write(reg_addr(llc_pmu_pkg::CntBase, i), 32'h100 * (i + 1));
    bus_write(llc_pmu_pkg::CtrlAddr, 32'h5);
    repeat (COUNT_CYCLES) begin
      rnd = xorshift_next();
      llc_events_i = rnd[NUM_EVENTS-1:0];
      next_cycle();
      model_step(llc_events_i);
      check_intr();
    end
    llc_events_i = '0;
    check_regs();

    // Saturation of counter 1
    bus_write(llc_pmu_pkg::CtrlAddr, 32'h2);
    bus_write(reg_addr(llc_pmu_pkg::ThrBase, 1), 32'd0);
    bus_write(reg_addr(llc_pmu_pkg::CntBase, 1), 32'hffff_fffd);
    llc_events_i = 4'b0010;
    repeat (5) begin
      next_cycle();
      model_step(llc_events_i);
    end
    llc_events_i = '0;
    check_read(reg_addr(llc_pmu_pkg::CntBase, 1));

    // Threshold 10 on counter 3, threshold 2 on counter 0 keeps a second status bit set
    bus_write(llc_pmu_pkg::CtrlAddr, 32'h0);
    bus_write(llc_pmu_pkg::StatusAddr, 32'hf);
    bus_write(reg_addr(llc_pmu_pkg::ThrBase, 0), 32'd2);
    bus_write(reg_addr(llc_pmu_pkg::ThrBase, 3), 32'd10);
    bus_write(reg_addr(llc_pmu_pkg::CntBase, 0), 32'd0);
    bus_write(reg_addr(llc_pmu_pkg::CntBase, 3), 32'd0);
    bus_write(llc_pmu_pkg::CtrlAddr, 32'h9);
    check_intr();
    llc_events_i = 4'b1001;
    repeat (12) begin
      next_cycle();
      model_step(llc_events_i);
      check_intr();
    end
    llc_events_i = '0;
    bus_write(llc_pmu_pkg::StatusAddr, 32'h8);
    check_intr();
    check_read(llc_pmu_pkg::StatusAddr);
    check_read(reg_addr(llc_pmu_pkg::CntBase, 3));

    // DMA event levels of random length
    pulse_base = pulse_cnt;
    for (int n = 0; n < DMA_EDGES; n++) begin
      hold = 3 + (xorshift_next() & 32'd3);
      dma_pe_evt_valid_i = 1'b1;
      repeat (hold) next_cycle();
      assert (dma_pe_evt_ack_o === 1'b1) else begin
        $display("DMA acknowledge did not rise while the event level was held");
        fail_cnt++;
      end
      dma_pe_evt_valid_i = 1'b0;
      repeat (hold) next_cycle();
      assert (dma_pe_evt_ack_o === 1'b0) else begin
        $display("DMA acknowledge did not fall after the event level dropped");
        fail_cnt++;
      end
    end
    assert (pulse_cnt - pulse_base == DMA_EDGES) else begin
      $display("ERR dma_pe_evt_o pulses: expected %h, actual %h", DMA_EDGES, pulse_cnt - pulse_base);
      err_cnt++;
    end

    $display("Summary: %0d value mismatches, %0d other assertion failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verification/llc_event_monitor_props.sv */
// Concurrent checks on the config handshakes, DMA event pulse and reset values, bound into the top
`timescale 1ns/100ps

module llc_event_monitor_props #(
  parameter int unsigned NUM_EVENTS = 4
) (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    dma_pe_evt_valid_i,
  input logic                    dma_pe_evt_ack_o,
  input logic                    dma_pe_evt_o,
  input logic                    cfg_aw_ready_o,
  input logic                    cfg_w_ready_o,
  input logic                    cfg_b_valid_o,
  input logic                    cfg_b_ready_i,
  input logic                    cfg_ar_ready_o,
  input logic                    cfg_r_valid_o,
  input llc_pmu_pkg::lite_data_t cfg_r_data_o,
  input logic                    cfg_r_ready_i,
  input logic [NUM_EVENTS-1:0]   pmu_intr_o
);

  b_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o)
    else $error("Write response dropped before its ready");

  r_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_r_valid_o && !cfg_r_ready_i |=> cfg_r_valid_o)
    else $error("Read response dropped before its ready");

  r_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_r_valid_o && !cfg_r_ready_i |=> $stable(cfg_r_data_o))
    else $error("Read data changed while the response was stalled");

  // One write and one read in flight
  ready_inverse: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_aw_ready_o == !cfg_b_valid_o && cfg_w_ready_o == !cfg_b_valid_o &&
    cfg_ar_ready_o == !cfg_r_valid_o)
    else $error("Ready does not mirror the pending response");

  dma_pulse_single: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_pe_evt_o |=> !dma_pe_evt_o)
    else $error("DMA event pulse lasted two cycles");

  // Pulse sits two edges behind a rising level seen at the input
  dma_pulse_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_pe_evt_o == ($past(dma_pe_evt_valid_i, 2) && !$past(dma_pe_evt_valid_i, 3)))
    else $error("DMA event pulse not two edges after the rising level");

  dma_ack_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_pe_evt_ack_o == $past(dma_pe_evt_valid_i, 2))
    else $error("DMA acknowledge does not follow the level by two edges");

  reset_outputs: assert property (@(posedge clk_i)
    rst_i |=> !cfg_b_valid_o && !cfg_r_valid_o && !dma_pe_evt_o && !dma_pe_evt_ack_o &&
    pmu_intr_o == '0)
    else $error("Outputs not low during reset");

endmodule

bind llc_event_monitor llc_event_monitor_props #(
  .NUM_EVENTS ( NUM_EVENTS )
) i_props (
  .clk_i              ( clk_i              ),
  .rst_i              ( rst_i              ),
  .dma_pe_evt_valid_i ( dma_pe_evt_valid_i ),
  .dma_pe_evt_ack_o   ( dma_pe_evt_ack_o   ),
  .dma_pe_evt_o       ( dma_pe_evt_o       ),
  .cfg_aw_ready_o     ( cfg_aw_ready_o     ),
  .cfg_w_ready_o      ( cfg_w_ready_o      ),
  .cfg_b_valid_o      ( cfg_b_valid_o      ),
  .cfg_b_ready_i      ( cfg_b_ready_i      ),
  .cfg_ar_ready_o     ( cfg_ar_ready_o     ),
  .cfg_r_valid_o      ( cfg_r_valid_o      ),
  .cfg_r_data_o       ( cfg_r_data_o       ),
  .cfg_r_ready_i      ( cfg_r_ready_i      ),
  .pmu_intr_o         ( pmu_intr_o         )
);

/* verilog/llc_event_monitor.sv */
// Top of the LLC event monitor: DMA event receiver, AXI4-Lite config slave and counter bank
`timescale 1ns/100ps

module llc_event_monitor #(
  parameter int unsigned NUM_EVENTS = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Cluster DMA processing-element event
  input  logic                    dma_pe_evt_valid_i,
  output logic                    dma_pe_evt_ack_o,
  output logic                    dma_pe_evt_o,
  // read hit, read miss, write hit, write miss
  input  logic [NUM_EVENTS-1:0]   llc_events_i,
  // Configuration port, write address and data
  input  logic                    cfg_aw_valid_i,
  input  llc_pmu_pkg::lite_addr_t cfg_aw_addr_i,
  output logic                    cfg_aw_ready_o,
  input  logic                    cfg_w_valid_i,
  input  llc_pmu_pkg::lite_data_t cfg_w_data_i,
  output logic                    cfg_w_ready_o,
  // Configuration port, write response
  output logic                    cfg_b_valid_o,
  input  logic                    cfg_b_ready_i,
  // Configuration port, read
  input  logic                    cfg_ar_valid_i,
  input  llc_pmu_pkg::lite_addr_t cfg_ar_addr_i,
  output logic                    cfg_ar_ready_o,
  output logic                    cfg_r_valid_o,
  output llc_pmu_pkg::lite_data_t cfg_r_data_o,
  input  logic                    cfg_r_ready_i,
  // Performance monitor interrupts
  output logic [NUM_EVENTS-1:0]   pmu_intr_o
);

  pmu_cfg_if #(
    .NUM_EVENTS ( NUM_EVENTS )
  ) cfg_bus ();

  edge_propagator_rx i_dma_pe_evt_rx (
    .clk_i   ( clk_i              ),
    .rst_i   ( rst_i              ),
    .valid_i ( dma_pe_evt_valid_i ),
    .valid_o ( dma_pe_evt_o       ),
    .ack_o   ( dma_pe_evt_ack_o   )
  );

  pmu_lite_slave i_cfg_slave (
    .clk_i      ( clk_i          ),
    .rst_i      ( rst_i          ),
    .aw_valid_i ( cfg_aw_valid_i ),
    .aw_addr_i  ( cfg_aw_addr_i  ),
    .aw_ready_o ( cfg_aw_ready_o ),
    .w_valid_i  ( cfg_w_valid_i  ),
    .w_data_i   ( cfg_w_data_i   ),
    .w_ready_o  ( cfg_w_ready_o  ),
    .b_valid_o  ( cfg_b_valid_o  ),
    .b_ready_i  ( cfg_b_ready_i  ),
    .ar_valid_i ( cfg_ar_valid_i ),
    .ar_addr_i  ( cfg_ar_addr_i  ),
    .ar_ready_o ( cfg_ar_ready_o ),
    .r_valid_o  ( cfg_r_valid_o  ),
    .r_data_o   ( cfg_r_data_o   ),
    .r_ready_i  ( cfg_r_ready_i  ),
    .cfg        ( cfg_bus        )
  );

  pmu_counter_bank #(
    .NUM_EVENTS ( NUM_EVENTS )
  ) i_counter_bank (
    .clk_i    ( clk_i        ),
    .rst_i    ( rst_i        ),
    .events_i ( llc_events_i ),
    .cfg      ( cfg_bus      ),
    .intr_o   ( pmu_intr_o   )
  );

endmodule

/* verilog/pmu_counter_bank.sv */
// Saturating LLC event counters with thresholds, enables and sticky interrupt status registers
`timescale 1ns/100ps

module pmu_counter_bank #(
  parameter int unsigned NUM_EVENTS = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [NUM_EVENTS-1:0] events_i,
  pmu_cfg_if.reg_side           cfg,
  output logic [NUM_EVENTS-1:0] intr_o
);

  llc_pmu_pkg::counter_t cnt_q [NUM_EVENTS];
  llc_pmu_pkg::counter_t thr_q [NUM_EVENTS];
  logic [NUM_EVENTS-1:0] en_q;
  logic [NUM_EVENTS-1:0] status_q;

  logic [NUM_EVENTS-1:0] cnt_wr;
  logic [NUM_EVENTS-1:0] thr_wr;
  logic                  ctrl_wr;
  logic                  status_wr;
  logic [NUM_EVENTS-1:0] cnt_inc;
  logic [NUM_EVENTS-1:0] thr_hit;
  logic [NUM_EVENTS-1:0] status_clr;
  logic [NUM_EVENTS-1:0] status_d;

  // Byte address of the idx-th word of an array starting at base
  function automatic llc_pmu_pkg::lite_addr_t slot_addr(
    llc_pmu_pkg::lite_addr_t base,
    int unsigned             idx
  );
    return base + llc_pmu_pkg::lite_addr_t'(4 * idx);
  endfunction

  // Write decode and per-counter next-step conditions
  always_comb begin
    for (int unsigned i = 0; i < NUM_EVENTS; i++) begin
      cnt_wr[i]  = cfg.wr_en && (cfg.wr_addr == slot_addr(llc_pmu_pkg::CntBase, i));
      thr_wr[i]  = cfg.wr_en && (cfg.wr_addr == slot_addr(llc_pmu_pkg::ThrBase, i));
      // Stops at all ones
      cnt_inc[i] = events_i[i] && en_q[i] && (cnt_q[i] != '1);
      // Counter steps from threshold-1 onto a nonzero threshold
      thr_hit[i] = cnt_inc[i] && !cnt_wr[i] && (thr_q[i] != '0) &&
                   ((cnt_q[i] + 32'd1) == thr_q[i]);
    end
  end

  assign ctrl_wr   = cfg.wr_en && (cfg.wr_addr == llc_pmu_pkg::CtrlAddr);
  assign status_wr = cfg.wr_en && (cfg.wr_addr == llc_pmu_pkg::StatusAddr);

  // W1C mask; a new hit in the same cycle still sets the bit
  assign status_clr = status_wr ? cfg.wr_data[NUM_EVENTS-1:0] : '0;
  assign status_d   = (status_q & ~status_clr) | thr_hit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int unsigned i = 0; i < NUM_EVENTS; i++) begin
        cnt_q[i] <= '0;
        thr_q[i] <= '0;
      end
      en_q     <= '0;
      status_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NUM_EVENTS; i++) begin
        // Software write takes priority over a same-cycle event
        if (cnt_wr[i]) begin
          cnt_q[i] <= cfg.wr_data;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
        if (thr_wr[i]) begin
          thr_q[i] <= cfg.wr_data;
        end
      end
      if (ctrl_wr) begin
        en_q <= cfg.wr_data[NUM_EVENTS-1:0];
      end
      status_q <= status_d;
    end
  end

  // Read mux, anything not matched returns the unmapped pattern
  always_comb begin
    cfg.rd_data = llc_pmu_pkg::UnmappedData;
    for (int unsigned i = 0; i < NUM_EVENTS; i++) begin
      if (cfg.rd_addr == slot_addr(llc_pmu_pkg::CntBase, i)) begin
        cfg.rd_data = cnt_q[i];
      end
      if (cfg.rd_addr == slot_addr(llc_pmu_pkg::ThrBase, i)) begin
        cfg.rd_data = thr_q[i];
      end
    end
    if (cfg.rd_addr == llc_pmu_pkg::CtrlAddr) begin
      cfg.rd_data = llc_pmu_pkg::lite_data_t'(en_q);
    end
    if (cfg.rd_addr == llc_pmu_pkg::StatusAddr) begin
      cfg.rd_data = llc_pmu_pkg::lite_data_t'(status_q);
    end
  end

  assign intr_o = status_q;

endmodule

/* verilog/pmu_lite_slave.sv */
// AXI4-Lite configuration slave with one write and one read in flight, drives the register channel
`timescale 1ns/100ps

module pmu_lite_slave (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Write address and data
  input  logic                    aw_valid_i,
  input  llc_pmu_pkg::lite_addr_t aw_addr_i,
  output logic                    aw_ready_o,
  input  logic                    w_valid_i,
  input  llc_pmu_pkg::lite_data_t w_data_i,
  output logic                    w_ready_o,
  // Write response, always OKAY
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  // Read channels
  input  logic                    ar_valid_i,
  input  llc_pmu_pkg::lite_addr_t ar_addr_i,
  output logic                    ar_ready_o,
  output logic                    r_valid_o,
  output llc_pmu_pkg::lite_data_t r_data_o,
  input  logic                    r_ready_i,
  // Register side
  pmu_cfg_if.bus_side             cfg
);

  logic                    b_valid_q;
  logic                    r_valid_q;
  llc_pmu_pkg::lite_data_t r_data_q;

  logic                    wr_accept;
  logic                    rd_accept;

  // Address and data are taken together, only while no response is pending
  assign aw_ready_o = ~b_valid_q;
  assign w_ready_o  = ~b_valid_q;
  assign wr_accept  = aw_valid_i & w_valid_i & ~b_valid_q;

  assign ar_ready_o = ~r_valid_q;
  assign rd_accept  = ar_valid_i & ~r_valid_q;

  // The register write lands on the accepting edge
  assign cfg.wr_en   = wr_accept;
  assign cfg.wr_addr = aw_addr_i;
  assign cfg.wr_data = w_data_i;

  // Read data is looked up in the same cycle the address is presented
  assign cfg.rd_addr = ar_addr_i;

  // Write response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  // Read response valid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_accept) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Captured at acceptance so the data holds while the master stalls
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= cfg.rd_data;
    end
  end

  assign b_valid_o = b_valid_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

/* verilog/edge_propagator_rx.sv */
// Receives the cluster DMA event level, acknowledges it and emits one pulse per rising level
`timescale 1ns/100ps

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  // Two-stage synchronizer, then one delay stage for edge detection
  logic sync1_q;
  logic sync2_q;
  logic delay_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      delay_q <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
      delay_q <= sync2_q;
    end
  end

  // Ack goes back to the cluster as the synchronized level
  assign ack_o   = sync2_q;

  // Rising edge of the synchronized level
  assign valid_o = sync2_q & ~delay_q;

endmodule

/* verilog/pmu_cfg_if.sv */
// Register access channel between the AXI4-Lite slave and the counter bank
`timescale 1ns/100ps

interface pmu_cfg_if #(
  parameter int unsigned NUM_EVENTS = 4
);

  // Write strobe is high for exactly one cycle per accepted write
  logic                    wr_en;
  llc_pmu_pkg::lite_addr_t wr_addr;
  llc_pmu_pkg::lite_data_t wr_data;

  // Read data is combinational from the read address
  llc_pmu_pkg::lite_addr_t rd_addr;
  llc_pmu_pkg::lite_data_t rd_data;

  modport bus_side (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_addr,
    input  rd_data
  );

  modport reg_side (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

  // The address map only has slots for MaxEvents counters
  if (NUM_EVENTS < 1 || NUM_EVENTS > llc_pmu_pkg::MaxEvents) begin : gen_num_events_check
    $fatal(1, "pmu_cfg_if: NUM_EVENTS must lie between 1 and MaxEvents");
  end

endinterface

/* verilog/llc_pmu_pkg.sv */
// Shared widths, data types and register map of the LLC event monitor, used by every RTL block
package llc_pmu_pkg;

  // Configuration bus types
  typedef logic [7:0]  lite_addr_t;
  typedef logic [31:0] lite_data_t;

  // One event counter or one threshold
  typedef logic [31:0] counter_t;

  // The register map has room for this many counters
  localparam int unsigned MaxEvents = 4;

  // Counter i lives at CntBase + 4*i
  localparam lite_addr_t CntBase = 8'h00;

  // Threshold i lives at ThrBase + 4*i
  localparam lite_addr_t ThrBase = 8'h10;

  // Enable register, bit i enables counter i
  localparam lite_addr_t CtrlAddr = 8'h20;

  // Interrupt status, write 1 to clear
  localparam lite_addr_t StatusAddr = 8'h24;

  // Read value for any address outside the map
  localparam lite_data_t UnmappedData = 32'hdeadf000;

endpackage
